/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_advtim
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@! grep -q "TESTBENCH FAILED" $(LOG)
	@grep -q "TESTBENCH PASSED" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* advtim_apb_cfg.sv */
`timescale 1ns/1ps
// APB register bank of the advanced timer
// control, shadow timing and channel registers, write-one commands,
// interrupt enable and status readback
module advtim_apb_cfg
	import advtim_reg_pkg::*;
	import advtim_gen_pkg::*;
#(
	parameter int ADDR_W = 32
)
(
	input  logic              reg_clk,
	input  logic              reg_rstn,
	input  logic [ADDR_W-1:0] paddr,
	input  logic              psel,
	input  logic              penable,
	input  logic              pwrite,
	input  logic [31:0]       pwdata,
	output logic [31:0]       prdata,
	advtim_cfg_if.src         shadow,
	output logic              gen_enable,
	output logic              hw_update_en,
	output logic              sw_update,
	output logic              logic_clr_req,
	output logic [1:0]        int_clr_req,
	output logic [1:0]        int_en,
	input  logic [1:0]        int_sta
);

logic       wr_en;
logic       rd_en;
logic       cmd_wr;
logic [1:0] int_sta_q0;
logic [1:0] int_sta_q1;

assign wr_en  = psel & penable & pwrite;
assign rd_en  = psel & penable & ~pwrite;
assign cmd_wr = wr_en && (paddr == ADDR_W'(cmd_addr));

// ==========================================================================
// register writes
// ==========================================================================
always_ff @(posedge reg_clk or negedge reg_rstn)
begin
	if (!reg_rstn)
	begin
		gen_enable   <= 1'b0;
		hw_update_en <= 1'b0;
		int_en       <= '0;
		shadow.psc   <= psc_rst;
		shadow.arr   <= arr_rst;
		shadow.cc1   <= '0;
		shadow.cc2   <= '0;
		shadow.oc1m  <= frozen_low;
		shadow.oc2m  <= frozen_low;
		shadow.cc1p  <= 1'b0;
		shadow.cc2p  <= 1'b0;
		shadow.cc1e  <= 1'b0;
		shadow.cc2e  <= 1'b0;
	end
	else if (wr_en)
	begin
		case (paddr)
			ADDR_W'(ctrl_addr):
			begin
				gen_enable   <= pwdata[ctrl_gen_enable];
				hw_update_en <= pwdata[ctrl_hw_update_en];
			end
			ADDR_W'(psc_addr): shadow.psc <= pwdata[cnt_w-1:0];
			ADDR_W'(arr_addr): shadow.arr <= pwdata[cnt_w-1:0];
			ADDR_W'(cc1_addr): shadow.cc1 <= pwdata[cnt_w-1:0];
			ADDR_W'(cc2_addr): shadow.cc2 <= pwdata[cnt_w-1:0];
			ADDR_W'(chcfg_addr):
			begin
				shadow.oc1m <= oc_mode_t'(pwdata[chcfg_oc1m_lsb +: 4]);
				shadow.oc2m <= oc_mode_t'(pwdata[chcfg_oc2m_lsb +: 4]);
				shadow.cc1p <= pwdata[chcfg_cc1p];
				shadow.cc2p <= pwdata[chcfg_cc2p];
				shadow.cc1e <= pwdata[chcfg_cc1e];
				shadow.cc2e <= pwdata[chcfg_cc2e];
			end
			ADDR_W'(int_addr): int_en <= pwdata[int_en_lsb +: 2];
			default: ;
		endcase
	end
end

// write-one commands high for the cycle after the access
always_ff @(posedge reg_clk or negedge reg_rstn)
begin
	if (!reg_rstn)
	begin
		sw_update     <= 1'b0;
		logic_clr_req <= 1'b0;
		int_clr_req   <= '0;
	end
	else
	begin
		sw_update     <= cmd_wr & pwdata[cmd_sw_update];
		logic_clr_req <= cmd_wr & pwdata[cmd_logic_clr];
		int_clr_req   <= {2{cmd_wr}} & pwdata[cmd_int_clr_lsb +: 2];
	end
end

// status comes from pe_clk
always_ff @(posedge reg_clk or negedge reg_rstn)
begin
	if (!reg_rstn)
	begin
		int_sta_q0 <= '0;
		int_sta_q1 <= '0;
	end
	else
	begin
		int_sta_q0 <= int_sta;
		int_sta_q1 <= int_sta_q0;
	end
end

// ==========================================================================
// readback
// ==========================================================================
always_comb
begin
	prdata = '0;
	if (rd_en)
	begin
		case (paddr)
			ADDR_W'(ctrl_addr):
			begin
				prdata[ctrl_gen_enable]   = gen_enable;
				prdata[ctrl_hw_update_en] = hw_update_en;
			end
			ADDR_W'(psc_addr): prdata[cnt_w-1:0] = shadow.psc;
			ADDR_W'(arr_addr): prdata[cnt_w-1:0] = shadow.arr;
			ADDR_W'(cc1_addr): prdata[cnt_w-1:0] = shadow.cc1;
			ADDR_W'(cc2_addr): prdata[cnt_w-1:0] = shadow.cc2;
			ADDR_W'(chcfg_addr):
			begin
				prdata[chcfg_oc1m_lsb +: 4] = shadow.oc1m;
				prdata[chcfg_oc2m_lsb +: 4] = shadow.oc2m;
				prdata[chcfg_cc1p]          = shadow.cc1p;
				prdata[chcfg_cc2p]          = shadow.cc2p;
				prdata[chcfg_cc1e]          = shadow.cc1e;
				prdata[chcfg_cc2e]          = shadow.cc2e;
			end
			ADDR_W'(int_addr):
			begin
				prdata[int_en_lsb +: 2]  = int_en;
				prdata[int_sta_lsb +: 2] = int_sta_q1;
			end
			default: prdata = '0;
		endcase
	end
end

endmodule

/* advtim_cfg_if.sv */
`timescale 1ns/1ps
// one full timer configuration
// timing values, output modes, channel polarity and enable
interface advtim_cfg_if
	import advtim_gen_pkg::*;
();

	logic [cnt_w-1:0] psc;
	logic [cnt_w-1:0] arr;
	logic [cnt_w-1:0] cc1;
	logic [cnt_w-1:0] cc2;
	oc_mode_t         oc1m;
	oc_mode_t         oc2m;
	logic             cc1p;
	logic             cc2p;
	logic             cc1e;
	logic             cc2e;

	modport src (output psc, arr, cc1, cc2, oc1m, oc2m, cc1p, cc2p, cc1e, cc2e);
	modport dst (input psc, arr, cc1, cc2, oc1m, oc2m, cc1p, cc2p, cc1e, cc2e);

endinterface

/* advtim_gen_pkg.sv */
// generator types of the advanced timer
// output-compare modes and counter width
package advtim_gen_pkg;

	localparam int cnt_w = 16;

	// unlisted codes decode as frozen_low
	typedef enum logic [3:0]
	{
		frozen_low     = 4'd0,
		pwm1           = 4'd1,
		pwm2           = 4'd2,
		force_active   = 4'd3,
		force_inactive = 4'd4
	} oc_mode_t;

endpackage

/* advtim_pwm_gen.sv */
`timescale 1ns/1ps
// two-channel PWM generator
// prescaler, up-counter with overflow, compare outputs by mode,
// sticky interrupt status
module advtim_pwm_gen
	import advtim_gen_pkg::*;
(
	input  logic       pe_clk,
	input  logic       pe_rstn,
	advtim_cfg_if.dst  cfg,
	input  logic       gen_enable,
	input  logic       logic_clr,
	input  logic [1:0] int_clr,
	input  logic [1:0] int_en,
	output logic       ch1_out,
	output logic       ch2_out,
	output logic       hw_update,
	output logic       running,
	output logic [1:0] int_sta,
	output logic       irq
);

logic [cnt_w-1:0] psc_cnt;
logic [cnt_w-1:0] cnt;
logic             tick;
logic             ovf;
logic             cc1_hit;
logic             ch1_ref;
logic             ch2_ref;

// reference level active through the match count
function automatic logic oc_ref(input oc_mode_t mode, input logic [cnt_w-1:0] count,
	input logic [cnt_w-1:0] cc);
	case (mode)
		pwm1:           return count <= cc;
		pwm2:           return count > cc;
		force_active:   return 1'b1;
		force_inactive: return 1'b0;
		default:        return 1'b0;
	endcase
endfunction

// ==========================================================================
// prescaler and counter
// ==========================================================================
assign tick = gen_enable && !logic_clr && (psc_cnt >= cfg.psc);
assign ovf  = tick && (cnt >= cfg.arr);

always_ff @(posedge pe_clk or negedge pe_rstn)
begin
	if (!pe_rstn)
	begin
		psc_cnt <= '0;
		cnt     <= '0;
	end
	else if (logic_clr)
	begin
		psc_cnt <= '0;
		cnt     <= '0;
	end
	else if (!gen_enable)
		psc_cnt <= '0;
	else if (tick)
	begin
		psc_cnt <= '0;
		cnt     <= ovf ? '0 : cnt + 1'b1;
	end
	else
		psc_cnt <= psc_cnt + 1'b1;
end

assign hw_update = ovf;
assign running   = gen_enable;

// ==========================================================================
// compare outputs
// ==========================================================================
assign ch1_ref = oc_ref(cfg.oc1m, cnt, cfg.cc1);
assign ch2_ref = oc_ref(cfg.oc2m, cnt, cfg.cc2);

always_ff @(posedge pe_clk or negedge pe_rstn)
begin
	if (!pe_rstn)
	begin
		ch1_out <= 1'b0;
		ch2_out <= 1'b0;
	end
	else
	begin
		ch1_out <= cfg.cc1e & (ch1_ref ^ cfg.cc1p);
		ch2_out <= cfg.cc2e & (ch2_ref ^ cfg.cc2p);
	end
end

// interrupt status with overflow in bit 0 and cc1 match in bit 1
assign cc1_hit = gen_enable && (cnt == cfg.cc1);

always_ff @(posedge pe_clk or negedge pe_rstn)
begin
	if (!pe_rstn)
		int_sta <= '0;
	else if (logic_clr)
		int_sta <= '0;
	else
		int_sta <= (int_sta & ~int_clr) | {cc1_hit, ovf};
end

assign irq = |(int_sta & int_en);

endmodule

/* advtim_reg_pkg.sv */
// register map of the advanced timer
// byte offsets, field positions and reset values
package advtim_reg_pkg;

	// byte offsets
	localparam logic [7:0] ctrl_addr  = 8'h00;
	localparam logic [7:0] cmd_addr   = 8'h04;
	localparam logic [7:0] psc_addr   = 8'h08;
	localparam logic [7:0] arr_addr   = 8'h0C;
	localparam logic [7:0] cc1_addr   = 8'h10;
	localparam logic [7:0] cc2_addr   = 8'h14;
	localparam logic [7:0] chcfg_addr = 8'h18;
	localparam logic [7:0] int_addr   = 8'h1C;

	// ctrl and cmd fields
	localparam int ctrl_gen_enable   = 0;
	localparam int ctrl_hw_update_en = 1;
	localparam int cmd_sw_update     = 0;
	localparam int cmd_logic_clr     = 1;
	localparam int cmd_int_clr_lsb   = 2;

	// chcfg fields
	localparam int chcfg_oc1m_lsb = 0;
	localparam int chcfg_oc2m_lsb = 4;
	localparam int chcfg_cc1p     = 8;
	localparam int chcfg_cc2p     = 9;
	localparam int chcfg_cc1e     = 10;
	localparam int chcfg_cc2e     = 11;

	// int fields
	localparam int int_en_lsb  = 0;
	localparam int int_sta_lsb = 2;

	// reset values of the shadow and active copies
	localparam logic [15:0] psc_rst = 16'd2;
	localparam logic [15:0] arr_rst = 16'h0032;

endpackage

/* advtim_regs_wrap.sv */
`timescale 1ns/1ps
// register wrap of the advanced timer
// command and level crossing into pe_clk, shadow to active loading
// with hardware update and running lock
module advtim_regs_wrap
	import advtim_reg_pkg::*;
	import advtim_gen_pkg::*;
(
	input  logic       reg_clk,
	input  logic       reg_rstn,
	input  logic       pe_clk,
	input  logic       pe_rstn,
	advtim_cfg_if.dst  shadow,
	advtim_cfg_if.src  active,
	input  logic       gen_enable_in,
	input  logic       hw_update_en_in,
	input  logic       sw_update,
	input  logic       logic_clr_req,
	input  logic [1:0] int_clr_req,
	output logic       gen_enable,
	output logic       logic_clr,
	output logic [1:0] int_clr,
	input  logic       hw_update,
	input  logic       running
);

logic [3:0] cmd_pulse;
logic [1:0] lvl_q0;
logic [1:0] lvl_q1;
logic       sw_update_s;
logic       hw_update_en_s;
logic       load_timing;
logic       load_channel;

// ==========================================================================
// clock crossing
// ==========================================================================
pulse_sync
#(
	.WIDTH      (4)
)
u_cmd_sync
(
	.src_clk    (reg_clk),
	.src_rstn   (reg_rstn),
	.src_pulse  ({int_clr_req, logic_clr_req, sw_update}),
	.pe_clk     (pe_clk),
	.pe_rstn    (pe_rstn),
	.dst_pulse  (cmd_pulse)
);

assign sw_update_s = cmd_pulse[0];
assign logic_clr   = cmd_pulse[1];
assign int_clr     = cmd_pulse[3:2];

always_ff @(posedge pe_clk or negedge pe_rstn)
begin
	if (!pe_rstn)
	begin
		lvl_q0 <= '0;
		lvl_q1 <= '0;
	end
	else
	begin
		lvl_q0 <= {hw_update_en_in, gen_enable_in};
		lvl_q1 <= lvl_q0;
	end
end

assign gen_enable     = lvl_q1[0];
assign hw_update_en_s = lvl_q1[1];

// ==========================================================================
// shadow to active
// shadow is quiet while the update command crosses
// ==========================================================================
assign load_timing  = sw_update_s | (hw_update & hw_update_en_s);
assign load_channel = sw_update_s & ~running;

always_ff @(posedge pe_clk or negedge pe_rstn)
begin
	if (!pe_rstn)
	begin
		active.psc  <= psc_rst;
		active.arr  <= arr_rst;
		active.cc1  <= '0;
		active.cc2  <= '0;
		active.oc1m <= frozen_low;
		active.oc2m <= frozen_low;
	end
	else if (load_timing)
	begin
		active.psc  <= shadow.psc;
		active.arr  <= shadow.arr;
		active.cc1  <= shadow.cc1;
		active.cc2  <= shadow.cc2;
		active.oc1m <= shadow.oc1m;
		active.oc2m <= shadow.oc2m;
	end
end

// polarity and enable locked while running
always_ff @(posedge pe_clk or negedge pe_rstn)
begin
	if (!pe_rstn)
	begin
		active.cc1p <= 1'b0;
		active.cc2p <= 1'b0;
		active.cc1e <= 1'b0;
		active.cc2e <= 1'b0;
	end
	else if (load_channel)
	begin
		active.cc1p <= shadow.cc1p;
		active.cc2p <= shadow.cc2p;
		active.cc1e <= shadow.cc1e;
		active.cc2e <= shadow.cc2e;
	end
end

endmodule

/* advtim_testdata.txt */
# columns in hex: W addr data | R addr expected | D pe_clk cycles
# P channel period expected_high | I expected irq level
R 08 2
R 0C 32
R 00 0
R 18 0
R 1C 0
W 08 0
W 0C 9
W 10 3
W 14 3
W 18 C21
R 18 C21
W 04 1
R 04 0
D 8
W 00 1
D 28
P 1 A 4
P 2 A 6
W 18 D21
W 04 1
D 10
P 1 A 4
W 00 0
D 8
W 04 1
D 8
W 00 1
D 28
P 1 A 6
W 00 0
W 18 C21
W 04 1
D 8
W 00 3
W 10 7
D 28
P 1 A 8
W 1C 1
R 1C D
I 1
W 00 0
W 04 C
D 10
I 0
R 1C 1
W 18 C43
W 04 1
D 8
P 1 A A
P 2 A 0

/* advtim_top.sv */
`timescale 1ns/1ps
// advanced timer top level
// APB register bank, register wrap and PWM generator
module advtim_top
#(
	parameter int ADDR_W = 32
)
(
	input  logic              reg_clk,
	input  logic              reg_rstn,
	input  logic              pe_clk,
	input  logic              pe_rstn,
	input  logic [ADDR_W-1:0] paddr,
	input  logic              psel,
	input  logic              penable,
	input  logic              pwrite,
	input  logic [31:0]       pwdata,
	output logic [31:0]       prdata,
	output logic              ch1_out,
	output logic              ch2_out,
	output logic              irq
);

logic       gen_enable_cfg;
logic       hw_update_en_cfg;
logic       sw_update;
logic       logic_clr_req;
logic [1:0] int_clr_req;
logic [1:0] int_en;
logic [1:0] int_sta;
logic       gen_enable_pe;
logic       logic_clr;
logic [1:0] int_clr;
logic       hw_update;
logic       running;

advtim_cfg_if shadow_cfg ();
advtim_cfg_if active_cfg ();

advtim_apb_cfg
#(
	.ADDR_W         (ADDR_W)
)
u_apb_cfg
(
	.reg_clk        (reg_clk),
	.reg_rstn       (reg_rstn),
	.paddr          (paddr),
	.psel           (psel),
	.penable        (penable),
	.pwrite         (pwrite),
	.pwdata         (pwdata),
	.prdata         (prdata),
	.shadow         (shadow_cfg),
	.gen_enable     (gen_enable_cfg),
	.hw_update_en   (hw_update_en_cfg),
	.sw_update      (sw_update),
	.logic_clr_req  (logic_clr_req),
	.int_clr_req    (int_clr_req),
	.int_en         (int_en),
	.int_sta        (int_sta)
);

advtim_regs_wrap u_regs_wrap
(
	.reg_clk         (reg_clk),
	.reg_rstn        (reg_rstn),
	.pe_clk          (pe_clk),
	.pe_rstn         (pe_rstn),
	.shadow          (shadow_cfg),
	.active          (active_cfg),
	.gen_enable_in   (gen_enable_cfg),
	.hw_update_en_in (hw_update_en_cfg),
	.sw_update       (sw_update),
	.logic_clr_req   (logic_clr_req),
	.int_clr_req     (int_clr_req),
	.gen_enable      (gen_enable_pe),
	.logic_clr       (logic_clr),
	.int_clr         (int_clr),
	.hw_update       (hw_update),
	.running         (running)
);

advtim_pwm_gen u_pwm_gen
(
	.pe_clk      (pe_clk),
	.pe_rstn     (pe_rstn),
	.cfg         (active_cfg),
	.gen_enable  (gen_enable_pe),
	.logic_clr   (logic_clr),
	.int_clr     (int_clr),
	.int_en      (int_en),
	.ch1_out     (ch1_out),
	.ch2_out     (ch2_out),
	.hw_update   (hw_update),
	.running     (running),
	.int_sta     (int_sta),
	.irq         (irq)
);

endmodule

/* build.f */
advtim_reg_pkg.sv
advtim_gen_pkg.sv
advtim_cfg_if.sv
pulse_sync.sv
advtim_apb_cfg.sv
advtim_regs_wrap.sv
advtim_pwm_gen.sv
advtim_top.sv
tb_advtim.sv

/* pulse_sync.sv */
`timescale 1ns/1ps
// toggle based pulse synchronizer with one lane per bit
// source pulse flips a toggle flop and destination detects the edge
module pulse_sync
#(
	parameter int WIDTH = 1
)
(
	input  logic             src_clk,
	input  logic             src_rstn,
	input  logic [WIDTH-1:0] src_pulse,
	input  logic             pe_clk,
	input  logic             pe_rstn,
	output logic [WIDTH-1:0] dst_pulse
);

logic [WIDTH-1:0] src_tgl;
logic [WIDTH-1:0] sync_q0;
logic [WIDTH-1:0] sync_q1;
logic [WIDTH-1:0] sync_q2;

always_ff @(posedge src_clk or negedge src_rstn)
begin
	if (!src_rstn)
		src_tgl <= '0;
	else
		src_tgl <= src_tgl ^ src_pulse;
end

// q0 and q1 resolve metastability and q2 holds the previous level
always_ff @(posedge pe_clk or negedge pe_rstn)
begin
	if (!pe_rstn)
	begin
		sync_q0 <= '0;
		sync_q1 <= '0;
		sync_q2 <= '0;
	end
	else
	begin
		sync_q0 <= src_tgl;
		sync_q1 <= sync_q0;
		sync_q2 <= sync_q1;
	end
end

assign dst_pulse = sync_q1 ^ sync_q2;

endmodule

/* tb_advtim.sv */
`timescale 1ns/1ps
// testbench of the advanced timer
// clocks and resets, APB write and read tasks, duty and irq checks,
// command file runner and timeout watchdog
module tb_advtim;

localparam string data_file  = "advtim_testdata.txt";
localparam int    apb_margin = 12;

logic        reg_clk;
logic        reg_rstn;
logic        pe_clk;
logic        pe_rstn;
logic [31:0] paddr;
logic        psel;
logic        penable;
logic        pwrite;
logic [31:0] pwdata;
logic [31:0] prdata;
logic        ch1_out;
logic        ch2_out;
logic        irq;

int               error_count;
int               check_count;
int               cycle_cnt;
int               cycle_limit;
bit               limit_ready;
logic [8*128-1:0] line_buf;

advtim_top
#(
	.ADDR_W   (32)
)
dut
(
	.reg_clk  (reg_clk),
	.reg_rstn (reg_rstn),
	.pe_clk   (pe_clk),
	.pe_rstn  (pe_rstn),
	.paddr    (paddr),
	.psel     (psel),
	.penable  (penable),
	.pwrite   (pwrite),
	.pwdata   (pwdata),
	.prdata   (prdata),
	.ch1_out  (ch1_out),
	.ch2_out  (ch2_out),
	.irq      (irq)
);

initial
begin
	pe_clk = 1'b0;
	forever #10 pe_clk = ~pe_clk;
end

initial
begin
	reg_clk = 1'b0;
	forever #15 reg_clk = ~reg_clk;
end

// ==========================================================================
// helpers
// ==========================================================================
task automatic check_value(input logic [31:0] got, input logic [31:0] expected,
	input string what);
	check_count++;
	if (got !== expected)
	begin
		error_count++;
		$display("Mismatch at %0t ns: %s got %h expected %h", $time, what, got, expected);
	end
endtask

task automatic apb_write(input logic [31:0] addr, input logic [31:0] data);
	@(negedge reg_clk);
	paddr   = addr;
	pwdata  = data;
	pwrite  = 1'b1;
	psel    = 1'b1;
	penable = 1'b0;
	@(negedge reg_clk);
	penable = 1'b1;
	@(negedge reg_clk);
	psel    = 1'b0;
	penable = 1'b0;
	pwrite  = 1'b0;
endtask

// prdata sampled while access is still driven
task automatic apb_read(input logic [31:0] addr, output logic [31:0] data);
	@(negedge reg_clk);
	paddr   = addr;
	pwrite  = 1'b0;
	psel    = 1'b1;
	penable = 1'b0;
	@(negedge reg_clk);
	penable = 1'b1;
	@(negedge reg_clk);
	data    = prdata;
	psel    = 1'b0;
	penable = 1'b0;
endtask

task automatic wait_cycles(input int n);
	repeat (n) @(negedge pe_clk);
endtask

// high cycles of one channel over a window of period cycles
task automatic measure_duty(input int ch, input int period, output int high_cnt);
	high_cnt = 0;
	repeat (period)
	begin
		@(negedge pe_clk);
		if ((ch == 1) ? ch1_out : ch2_out)
			high_cnt++;
	end
endtask

// ==========================================================================
// command file runner
// without execute it only sums up the cycle budget
// ==========================================================================
task automatic run_file(input bit execute);
	int          fd;
	int          code;
	int          high_cnt;
	bit          done;
	logic [7:0]  op;
	logic [31:0] arg_a;
	logic [31:0] arg_b;
	logic [31:0] arg_c;
	logic [31:0] rd_data;
	fd = $fopen(data_file, "r");
	if (fd == 0)
	begin
		$display("could not open the command file %s", data_file);
		error_count++;
		return;
	end
	done = 1'b0;
	while (!done)
	begin
		code = $fscanf(fd, "%s", op);
		if (code != 1)
			done = 1'b1;
		else
		begin
			cycle_limit += execute ? 0 : apb_margin;
			case (op)
				"#": code = $fgets(line_buf, fd);
				"W":
				begin
					code = $fscanf(fd, "%h %h", arg_a, arg_b);
					if (execute)
						apb_write(arg_a, arg_b);
				end
				"R":
				begin
					code = $fscanf(fd, "%h %h", arg_a, arg_b);
					if (execute)
					begin
						apb_read(arg_a, rd_data);
						check_value(rd_data, arg_b, $sformatf("read of addr %h", arg_a));
					end
				end
				"D":
				begin
					code = $fscanf(fd, "%h", arg_a);
					if (execute)
						wait_cycles(arg_a);
					else
						cycle_limit += arg_a;
				end
				"P":
				begin
					code = $fscanf(fd, "%h %h %h", arg_a, arg_b, arg_c);
					if (execute)
					begin
						measure_duty(arg_a, arg_b, high_cnt);
						check_value(high_cnt, arg_c, $sformatf("ch%0d high cycles", arg_a));
					end
					else
						cycle_limit += arg_b;
				end
				"I":
				begin
					code = $fscanf(fd, "%h", arg_a);
					if (execute)
					begin
						@(negedge pe_clk);
						check_value(32'(irq), arg_a, "irq level");
					end
				end
				default:
				begin
					if (execute)
					begin
						$display("unknown opcode %s in the command file", op);
						error_count++;
					end
					done = 1'b1;
				end
			endcase
		end
	end
	$fclose(fd);
endtask

// ==========================================================================
// main flow
// ==========================================================================
initial
begin
	paddr       = '0;
	psel        = 1'b0;
	penable     = 1'b0;
	pwrite      = 1'b0;
	pwdata      = '0;
	pe_rstn     = 1'b0;
	reg_rstn    = 1'b0;
	error_count = 0;
	check_count = 0;
	cycle_limit = 200;
	limit_ready = 1'b0;
	run_file(1'b0);
	limit_ready = 1'b1;
	repeat (8) @(negedge pe_clk);
	pe_rstn  = 1'b1;
	reg_rstn = 1'b1;
	wait_cycles(4);
	run_file(1'b1);
	$display("checks %0d, errors %0d", check_count, error_count);
	if (error_count == 0)
		$display("TESTBENCH PASSED");
	else
		$display("TESTBENCH FAILED");
	$finish;
end

initial
begin
	cycle_cnt = 0;
	wait (limit_ready);
	while (cycle_cnt < cycle_limit)
	begin
		@(posedge pe_clk);
		cycle_cnt++;
	end
	$display("timeout, the run did not finish within %0d pe_clk cycles", cycle_limit);
	$display("checks %0d, errors %0d", check_count, error_count);
	$display("TESTBENCH FAILED");
	$finish;
end

endmodule
